//--- hdl/vtp_tlb_macros.svh
// Size settings for the set-associative TLB
// Included by the package and by every RTL file that needs a width or a count

`ifndef VTP_TLB_MACROS_SVH
`define VTP_TLB_MACROS_SVH

// Associativity and number of sets
`define TLB_WAYS 4
`define TLB_SETS 64

// Set index width, log2 of the set count
`define TLB_IDX_BITS 6

// Page number widths on the virtual and physical sides
`define TLB_VA_PAGE_BITS 20
`define TLB_PA_PAGE_BITS 16

// Register stages between an accepted lookup and its response register
`define TLB_LOOKUP_STAGES 4

// Idle cycles the fill FSM waits after each insert
`define TLB_FILL_BUBBLE 3

`endif

//--- hdl/vtp_tlb_pkg.sv
// Shared types of the TLB
// Every RTL file refers to these through vtp_tlb_pkg:: scoped names

`include "vtp_tlb_macros.svh"

package vtp_tlb_pkg;

    // ====================
    // Page numbers
    // ====================

    // Virtual page number as presented on the lookup and fill ports
    typedef logic [`TLB_VA_PAGE_BITS-1:0] tlb_va_page_t;

    // Physical page number returned on a hit
    typedef logic [`TLB_PA_PAGE_BITS-1:0] tlb_pa_page_t;

    // Set index, taken from the low bits of the virtual page
    typedef logic [`TLB_IDX_BITS-1:0] tlb_idx_t;

    // Tag is whatever is left of the virtual page above the index
    typedef logic [`TLB_VA_PAGE_BITS-`TLB_IDX_BITS-1:0] tlb_tag_t;

    // ====================
    // Storage and requests
    // ====================

    // One stored translation; valid is cleared by the init sweep
    typedef struct packed {
        logic         valid;
        tlb_tag_t     tag;
        tlb_pa_page_t pa;
    } tlb_entry_t;

    // Write to the way RAMs, the one-hot mask selects the target ways
    typedef struct packed {
        logic [`TLB_WAYS-1:0] way_mask;
        tlb_idx_t             idx;
        tlb_entry_t           entry;
    } tlb_wr_t;

    // New translation from the page walker
    typedef struct packed {
        tlb_va_page_t va;
        tlb_pa_page_t pa;
    } tlb_fill_req_t;

    // Lookup result, valid for one cycle when hit or miss is set
    typedef struct packed {
        logic         hit;
        logic         miss;
        tlb_va_page_t va;
        tlb_pa_page_t pa;
    } tlb_lookup_rsp_t;

    // Fill FSM states
    typedef enum logic [1:0] {
        FILL_INIT,
        FILL_IDLE,
        FILL_INSERT,
        FILL_BUBBLE
    } fill_state_t;

endpackage

//--- hdl/tlb_way_ram.sv
// Block RAM holding one way of the TLB
// One read port with two cycles of latency and one independent write port

`include "vtp_tlb_macros.svh"

module tlb_way_ram
(
    input  logic                    clk,
    input  vtp_tlb_pkg::tlb_idx_t   rd_idx,
    output vtp_tlb_pkg::tlb_entry_t rd_entry,
    input  logic                    wr_en,
    input  vtp_tlb_pkg::tlb_idx_t   wr_idx,
    input  vtp_tlb_pkg::tlb_entry_t wr_entry
);

    // One entry per set
    vtp_tlb_pkg::tlb_entry_t mem [`TLB_SETS];

    // Registered read address, the first of the two read cycles
    vtp_tlb_pkg::tlb_idx_t rd_idx_q;

    // Write port, the new entry is in the array after the edge
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_idx] <= wr_entry;
        end
    end

    // Read port with an address register and an output register
    // A read in the same cycle as a write to that set returns the old entry
    always_ff @(posedge clk)
    begin
        rd_idx_q <= rd_idx;
        rd_entry <= mem[rd_idx_q];
    end

endmodule

//--- hdl/tlb_init_sweep.sv
// Clears the TLB after reset by walking every set once
// Each cycle it writes an invalid entry to all ways of one set,
// then holds sweep_done high until the next reset

`include "vtp_tlb_macros.svh"

module tlb_init_sweep
(
    input  logic                 clk,
    input  logic                 reset,
    output vtp_tlb_pkg::tlb_wr_t sweep_wr,
    output logic                 sweep_done
);

    // Set being cleared in the current cycle
    vtp_tlb_pkg::tlb_idx_t set_cnt;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            set_cnt    <= '0;
            sweep_done <= 1'b0;
        end
        else if (!sweep_done)
        begin
            set_cnt <= set_cnt + 1'b1;

            // Last set is written at this edge, so the sweep ends here
            if (set_cnt == vtp_tlb_pkg::tlb_idx_t'(`TLB_SETS - 1))
            begin
                sweep_done <= 1'b1;
            end
        end
    end

    // All ways of the set are written at once while the sweep runs
    // An all-zero entry has valid low, which is all the clear needs
    always_comb
    begin
        sweep_wr          = '0;
        sweep_wr.way_mask = {`TLB_WAYS{!sweep_done}};
        sweep_wr.idx      = set_cnt;
    end

endmodule

//--- hdl/tlb_fill_ctrl.sv
// Fill FSM of the TLB
// Takes new translations from the page walker, writes each one into the
// round-robin victim way and owns the single write port of the way RAMs

`include "vtp_tlb_macros.svh"

module tlb_fill_ctrl
(
    input  logic                       clk,
    input  logic                       reset,
    input  vtp_tlb_pkg::tlb_wr_t       sweep_wr,
    input  logic                       sweep_done,
    input  logic                       fill_en,
    input  vtp_tlb_pkg::tlb_fill_req_t fill,
    output logic                       fill_rdy,
    output logic                       lookup_rdy,
    output vtp_tlb_pkg::tlb_wr_t       ram_wr
);

    vtp_tlb_pkg::fill_state_t state;

    // Translation captured when the fill is accepted
    vtp_tlb_pkg::tlb_fill_req_t fill_q;

    // Global victim pointer, shared by all sets
    logic [$clog2(`TLB_WAYS)-1:0] victim;

    // Remaining bubble cycles after the current one
    logic [$clog2(`TLB_FILL_BUBBLE)-1:0] bubble_cnt;

    // ====================
    // Ready outputs
    // ====================

    // In the first cycle after the sweep the FSM is still in FILL_INIT
    // It accepts a fill there exactly as it would in FILL_IDLE
    assign fill_rdy = (state == vtp_tlb_pkg::FILL_IDLE) ||
                      ((state == vtp_tlb_pkg::FILL_INIT) && sweep_done);

    // Lookups are held off during the one insert cycle
    assign lookup_rdy = sweep_done && (state != vtp_tlb_pkg::FILL_INSERT);

    // ====================
    // FSM
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= vtp_tlb_pkg::FILL_INIT;
            victim     <= '0;
            bubble_cnt <= '0;
        end
        else
        begin
            case (state)
                vtp_tlb_pkg::FILL_INIT, vtp_tlb_pkg::FILL_IDLE:
                begin
                    if (fill_rdy)
                    begin
                        state <= fill_en ? vtp_tlb_pkg::FILL_INSERT : vtp_tlb_pkg::FILL_IDLE;
                    end
                end

                vtp_tlb_pkg::FILL_INSERT:
                begin
                    // The write happens at this edge, move on to the next victim
                    victim     <= victim + 1'b1;
                    bubble_cnt <= ($clog2(`TLB_FILL_BUBBLE))'(`TLB_FILL_BUBBLE - 1);
                    state      <= vtp_tlb_pkg::FILL_BUBBLE;
                end

                vtp_tlb_pkg::FILL_BUBBLE:
                begin
                    if (bubble_cnt == '0)
                    begin
                        state <= vtp_tlb_pkg::FILL_IDLE;
                    end
                    else
                    begin
                        bubble_cnt <= bubble_cnt - 1'b1;
                    end
                end

                default:
                begin
                    state <= vtp_tlb_pkg::FILL_INIT;
                end
            endcase
        end
    end

    // Payload register for the accepted fill
    always_ff @(posedge clk)
    begin
        if (fill_rdy && fill_en)
        begin
            fill_q <= fill;
        end
    end

    // ====================
    // Write port mux
    // ====================

    // Sweep writes during init, the captured fill during insert, else nothing
    always_comb
    begin
        ram_wr = '0;
        case (state)
            vtp_tlb_pkg::FILL_INIT:
            begin
                ram_wr = sweep_wr;
            end

            vtp_tlb_pkg::FILL_INSERT:
            begin
                for (int w = 0; w < `TLB_WAYS; w++)
                begin
                    ram_wr.way_mask[w] = (victim == w);
                end
                // Split the virtual page into set index and tag
                ram_wr.idx         = vtp_tlb_pkg::tlb_idx_t'(fill_q.va);
                ram_wr.entry.valid = 1'b1;
                ram_wr.entry.tag   = fill_q.va[`TLB_VA_PAGE_BITS-1:`TLB_IDX_BITS];
                ram_wr.entry.pa    = fill_q.pa;
            end

            default:
            begin
                ram_wr = '0;
            end
        endcase
    end

endmodule

//--- hdl/tlb_lookup_pipe.sv
// Lookup pipeline of the TLB
// Reads all ways of the set, compares tags in two steps and registers
// the response, four cycles after the lookup is accepted

`include "vtp_tlb_macros.svh"

module tlb_lookup_pipe
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         lookup_en,
    input  vtp_tlb_pkg::tlb_va_page_t    lookup_va,
    output vtp_tlb_pkg::tlb_idx_t        rd_idx,
    input  vtp_tlb_pkg::tlb_entry_t      rd_entry [`TLB_WAYS],
    output vtp_tlb_pkg::tlb_lookup_rsp_t lookup_rsp
);

    // Lookup state per stage
    // Stage 1 waits on the RAM address register, stage 2 sees the RAM data,
    // stage 3 holds the XOR result and stage 4 the per-way hit bits
    logic                      stg_valid [1:`TLB_LOOKUP_STAGES];
    vtp_tlb_pkg::tlb_va_page_t stg_va    [1:`TLB_LOOKUP_STAGES];

    // Stage 3 registers
    vtp_tlb_pkg::tlb_tag_t     xor_tag   [`TLB_WAYS];
    logic [`TLB_WAYS-1:0]      ent_valid;
    vtp_tlb_pkg::tlb_pa_page_t stg3_pa   [`TLB_WAYS];

    // Stage 4 registers
    logic [`TLB_WAYS-1:0]      hit_vec;
    vtp_tlb_pkg::tlb_pa_page_t stg4_pa   [`TLB_WAYS];

    // Physical page of the lowest hitting way
    vtp_tlb_pkg::tlb_pa_page_t pa_sel;

    // The set index goes straight to the RAM address registers
    assign rd_idx = vtp_tlb_pkg::tlb_idx_t'(lookup_va);

    // ====================
    // Stage state
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int s = 1; s <= `TLB_LOOKUP_STAGES; s++)
            begin
                stg_valid[s] <= 1'b0;
            end
        end
        else
        begin
            stg_valid[1] <= lookup_en;
            for (int s = 1; s < `TLB_LOOKUP_STAGES; s++)
            begin
                stg_valid[s+1] <= stg_valid[s];
            end
        end

        stg_va[1] <= lookup_va;
        for (int s = 1; s < `TLB_LOOKUP_STAGES; s++)
        begin
            stg_va[s+1] <= stg_va[s];
        end
    end

    // ====================
    // Tag compare
    // ====================

    // First half of the compare, a plain XOR per way
    // Full reduction in one cycle would be too deep next to the RAM output
    always_ff @(posedge clk)
    begin
        for (int w = 0; w < `TLB_WAYS; w++)
        begin
            xor_tag[w]   <= rd_entry[w].tag ^ stg_va[2][`TLB_VA_PAGE_BITS-1:`TLB_IDX_BITS];
            ent_valid[w] <= rd_entry[w].valid;
            stg3_pa[w]   <= rd_entry[w].pa;
        end
    end

    // Second half, a way hits when its entry is valid and no tag bit differs
    always_ff @(posedge clk)
    begin
        for (int w = 0; w < `TLB_WAYS; w++)
        begin
            hit_vec[w] <= ent_valid[w] && !(|xor_tag[w]);
            stg4_pa[w] <= stg3_pa[w];
        end
    end

    // Lowest way wins when more than one hits
    always_comb
    begin
        pa_sel = '0;
        for (int w = `TLB_WAYS - 1; w >= 0; w--)
        begin
            if (hit_vec[w])
            begin
                pa_sel = stg4_pa[w];
            end
        end
    end

    // ====================
    // Response register
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lookup_rsp.hit  <= 1'b0;
            lookup_rsp.miss <= 1'b0;
        end
        else
        begin
            lookup_rsp.hit  <= stg_valid[`TLB_LOOKUP_STAGES] && (|hit_vec);
            lookup_rsp.miss <= stg_valid[`TLB_LOOKUP_STAGES] && !(|hit_vec);
        end

        lookup_rsp.va <= stg_va[`TLB_LOOKUP_STAGES];
        lookup_rsp.pa <= pa_sel;
    end

endmodule

//--- hdl/vtp_tlb.sv
// Top level of the 4-way, 64-set TLB
// Lookups go in on lookup_en while lookup_rdy is high and come back on
// lookup_rsp four cycles later; fills go in on fill_en while fill_rdy is high

`include "vtp_tlb_macros.svh"

module vtp_tlb
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         lookup_en,
    input  vtp_tlb_pkg::tlb_va_page_t    lookup_va,
    output logic                         lookup_rdy,
    output vtp_tlb_pkg::tlb_lookup_rsp_t lookup_rsp,
    input  logic                         fill_en,
    input  vtp_tlb_pkg::tlb_fill_req_t   fill,
    output logic                         fill_rdy
);

    // Sweep to fill control
    vtp_tlb_pkg::tlb_wr_t sweep_wr;
    logic                 sweep_done;

    // Shared write bus to all ways
    vtp_tlb_pkg::tlb_wr_t ram_wr;

    // Read address broadcast to all ways, data returned per way
    vtp_tlb_pkg::tlb_idx_t   rd_idx;
    vtp_tlb_pkg::tlb_entry_t rd_entry [`TLB_WAYS];

    tlb_init_sweep u_init_sweep
    (
        .clk        (clk),
        .reset      (reset),
        .sweep_wr   (sweep_wr),
        .sweep_done (sweep_done)
    );

    tlb_fill_ctrl u_fill_ctrl
    (
        .clk        (clk),
        .reset      (reset),
        .sweep_wr   (sweep_wr),
        .sweep_done (sweep_done),
        .fill_en    (fill_en),
        .fill       (fill),
        .fill_rdy   (fill_rdy),
        .lookup_rdy (lookup_rdy),
        .ram_wr     (ram_wr)
    );

    tlb_lookup_pipe u_lookup_pipe
    (
        .clk        (clk),
        .reset      (reset),
        .lookup_en  (lookup_en),
        .lookup_va  (lookup_va),
        .rd_idx     (rd_idx),
        .rd_entry   (rd_entry),
        .lookup_rsp (lookup_rsp)
    );

    // One RAM per way, each enabled by its bit of the way mask
    for (genvar w = 0; w < `TLB_WAYS; w++)
    begin : gen_way
        tlb_way_ram u_way_ram
        (
            .clk      (clk),
            .rd_idx   (rd_idx),
            .rd_entry (rd_entry[w]),
            .wr_en    (ram_wr.way_mask[w]),
            .wr_idx   (ram_wr.idx),
            .wr_entry (ram_wr.entry)
        );
    end

endmodule

//--- verif/tb_clock_gen.sv
// Clock source for the TLB testbench
// Free-running clock with a 20 ns period, starting low at time zero

module tb_clock_gen
(
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    // Half of the 20 ns period
    localparam int HALF_PERIOD = 10;

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

//--- verif/vtp_tlb_checker.sv
// Timing assertions for the TLB, attached to vtp_tlb with bind
// Covers the init sweep, the fixed lookup latency and the fill handshake

`include "vtp_tlb_macros.svh"

module vtp_tlb_checker
(
    input logic                         clk,
    input logic                         reset,
    input logic                         lookup_en,
    input logic                         lookup_rdy,
    input vtp_tlb_pkg::tlb_lookup_rsp_t lookup_rsp,
    input logic                         fill_en,
    input logic                         fill_rdy,
    input logic                         sweep_done
);
    timeunit 1ns;
    timeprecision 1ps;

    // Number of failed assertions, read by the testbench at the end of the run
    int fail_cnt = 0;

    // Clock edges since reset was released, saturates well past the sweep
    int unsigned since_reset = 0;

    logic accept;
    logic fill_accept;
    logic rsp_valid;

    assign accept      = lookup_en && lookup_rdy;
    assign fill_accept = fill_en && fill_rdy;
    assign rsp_valid   = lookup_rsp.hit || lookup_rsp.miss;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            since_reset <= 0;
        end
        else if (since_reset < 1000)
        begin
            since_reset <= since_reset + 1;
        end
    end

    // ====================
    // Init sweep
    // ====================

    // Both ready outputs stay low while the sweep clears the sets
    sweep_ready_low: assert property (@(posedge clk) disable iff (reset)
        (since_reset < `TLB_SETS) |-> (!lookup_rdy && !fill_rdy))
    else begin $error("ready output high during the init sweep"); fail_cnt++; end

    // And both come up in the first cycle after the last set
    sweep_ready_high: assert property (@(posedge clk) disable iff (reset)
        (since_reset == `TLB_SETS) |-> (lookup_rdy && fill_rdy))
    else begin $error("ready outputs not high after the init sweep"); fail_cnt++; end

    // No response can come out before the sweep has finished
    sweep_no_rsp: assert property (@(posedge clk) disable iff (reset)
        !sweep_done |-> !rsp_valid)
    else begin $error("lookup response during the init sweep"); fail_cnt++; end

    // ====================
    // Lookup response
    // ====================

    rsp_one_hot: assert property (@(posedge clk) disable iff (reset)
        !(lookup_rsp.hit && lookup_rsp.miss))
    else begin $error("hit and miss set together"); fail_cnt++; end

    // Response register loads four edges after the accept, seen one edge later
    rsp_latency: assert property (@(posedge clk) disable iff (reset)
        rsp_valid == $past(accept, `TLB_LOOKUP_STAGES + 1))
    else begin $error("lookup response not exactly four cycles after lookup_en"); fail_cnt++; end

    // ====================
    // Handshakes
    // ====================

    strobe_lookup_legal: assert property (@(posedge clk) disable iff (reset)
        lookup_en |-> lookup_rdy)
    else begin $error("lookup_en while lookup_rdy is low"); fail_cnt++; end

    strobe_fill_legal: assert property (@(posedge clk) disable iff (reset)
        fill_en |-> fill_rdy)
    else begin $error("fill_en while fill_rdy is low"); fail_cnt++; end

    // The insert cycle blocks lookups for exactly one cycle
    fill_blocks_lookup: assert property (@(posedge clk) disable iff (reset)
        fill_accept |=> !lookup_rdy ##1 lookup_rdy)
    else begin $error("lookup_rdy not low for exactly one cycle after a fill"); fail_cnt++; end

    // Insert plus three bubble cycles keep fill_rdy low
    fill_busy: assert property (@(posedge clk) disable iff (reset)
        fill_accept |=> !fill_rdy ##1 !fill_rdy ##1 !fill_rdy ##1 !fill_rdy ##1 fill_rdy)
    else begin $error("fill_rdy not low for exactly four cycles after a fill"); fail_cnt++; end

endmodule

//--- verif/vtp_tlb_tb.sv
// Testbench for the TLB
// Runs the sweep, fill, replacement and random tests against a reference
// model of the sets and the round-robin victim pointer
// Timing rules are covered by the bound checker

`include "vtp_tlb_macros.svh"

module vtp_tlb_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DRIVE_DELAY    = 2;
    localparam int TEST_CYCLES    = 1500;
    // About twice the expected length of all tests
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
    localparam int RSP_DELAY      = `TLB_LOOKUP_STAGES + 1;
    localparam int TAG_LSB        = `TLB_IDX_BITS;
    localparam int VA_MSB         = `TLB_VA_PAGE_BITS - 1;
    localparam int POOL_SIZE      = 16;

    // Lookup in flight with the cycle its response is due and the expected response
    typedef struct packed {
        int unsigned                  due;
        vtp_tlb_pkg::tlb_lookup_rsp_t rsp;
    } pending_t;

    logic                         clk;
    logic                         reset;
    logic                         lookup_en;
    vtp_tlb_pkg::tlb_va_page_t    lookup_va;
    logic                         lookup_rdy;
    vtp_tlb_pkg::tlb_lookup_rsp_t lookup_rsp;
    logic                         fill_en;
    vtp_tlb_pkg::tlb_fill_req_t   fill;
    logic                         fill_rdy;

    // Reference model that only the fills issued by the testbench change
    vtp_tlb_pkg::tlb_entry_t   model [`TLB_SETS][`TLB_WAYS];
    int unsigned               model_victim;
    pending_t                  pending_q [$];
    vtp_tlb_pkg::tlb_va_page_t pool [POOL_SIZE];

    int unsigned cycle;
    int          err_cnt;
    int          tests_pass;
    int          tests_fail;

    tb_clock_gen u_clock_gen
    (
        .clk (clk)
    );

    vtp_tlb u_vtp_tlb
    (
        .clk        (clk),
        .reset      (reset),
        .lookup_en  (lookup_en),
        .lookup_va  (lookup_va),
        .lookup_rdy (lookup_rdy),
        .lookup_rsp (lookup_rsp),
        .fill_en    (fill_en),
        .fill       (fill),
        .fill_rdy   (fill_rdy)
    );

    bind vtp_tlb vtp_tlb_checker u_checker
    (
        .clk        (clk),
        .reset      (reset),
        .lookup_en  (lookup_en),
        .lookup_rdy (lookup_rdy),
        .lookup_rsp (lookup_rsp),
        .fill_en    (fill_en),
        .fill_rdy   (fill_rdy),
        .sweep_done (sweep_done)
    );

    // ====================
    // Model and reporting
    // ====================

    function automatic int total_errors();
        return err_cnt + u_vtp_tlb.u_checker.fail_cnt;
    endfunction

    function automatic void report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        $display("[FAIL] %0d ns %s expected %0h got %0h", $time, name, exp, act);
        err_cnt++;
    endfunction

    function automatic void report_error(string what);
        $display("[ERROR] %0d ns %s", $time, what);
        err_cnt++;
    endfunction

    // A valid entry with a matching tag hits and the lowest such way wins
    function automatic vtp_tlb_pkg::tlb_lookup_rsp_t predict(vtp_tlb_pkg::tlb_va_page_t va);
        vtp_tlb_pkg::tlb_lookup_rsp_t rsp;
        int unsigned                  set_i;
        rsp    = '0;
        rsp.va = va;
        set_i  = va[TAG_LSB-1:0];
        for (int w = `TLB_WAYS - 1; w >= 0; w--)
        begin
            if (model[set_i][w].valid && (model[set_i][w].tag == va[VA_MSB:TAG_LSB]))
            begin
                rsp.hit = 1'b1;
                rsp.pa  = model[set_i][w].pa;
            end
        end
        rsp.miss = !rsp.hit;
        return rsp;
    endfunction

    function automatic void model_fill(vtp_tlb_pkg::tlb_fill_req_t req);
        int unsigned set_i;
        set_i = req.va[TAG_LSB-1:0];
        model[set_i][model_victim].valid = 1'b1;
        model[set_i][model_victim].tag   = req.va[VA_MSB:TAG_LSB];
        model[set_i][model_victim].pa    = req.pa;
        model_victim = (model_victim + 1) % `TLB_WAYS;
    endfunction

    function automatic void check_response(pending_t p);
        if (p.due != cycle)
            report_mismatch("lookup_rsp cycle", p.due, cycle);
        if (lookup_rsp.hit != p.rsp.hit)
            report_mismatch("lookup_rsp.hit", p.rsp.hit, lookup_rsp.hit);
        if (lookup_rsp.miss != p.rsp.miss)
            report_mismatch("lookup_rsp.miss", p.rsp.miss, lookup_rsp.miss);
        if (lookup_rsp.va != p.rsp.va)
            report_mismatch("lookup_rsp.va", p.rsp.va, lookup_rsp.va);
        if (p.rsp.hit && (lookup_rsp.pa != p.rsp.pa))
            report_mismatch("lookup_rsp.pa", p.rsp.pa, lookup_rsp.pa);
    endfunction

    // Responses are checked first and a lookup sees the model from before a fill
    // accepted at the same edge
    // The DUT RAM read returns the old entry in that case too
    always @(posedge clk)
    begin
        if (reset)
        begin
            pending_q.delete();
        end
        else
        begin
            if (lookup_rsp.hit || lookup_rsp.miss)
            begin
                if (pending_q.size() == 0)
                    report_error("response without an outstanding lookup");
                else
                    check_response(pending_q.pop_front());
            end
            else if ((pending_q.size() != 0) && (pending_q[0].due == cycle))
            begin
                report_error("no response for a lookup four cycles after lookup_en");
                void'(pending_q.pop_front());
            end
            if (lookup_en && lookup_rdy)
                pending_q.push_back('{due: cycle + RSP_DELAY, rsp: predict(lookup_va)});
            if (fill_en && fill_rdy)
                model_fill(fill);
        end
        cycle++;
    end

    // ====================
    // Drivers
    // ====================

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic lookup(vtp_tlb_pkg::tlb_va_page_t va);
        while (!lookup_rdy)
            step();
        lookup_en = 1'b1;
        lookup_va = va;
        step();
        lookup_en = 1'b0;
    endtask

    task automatic fill_entry(vtp_tlb_pkg::tlb_va_page_t va, vtp_tlb_pkg::tlb_pa_page_t pa);
        while (!fill_rdy)
            step();
        fill_en = 1'b1;
        fill.va = va;
        fill.pa = pa;
        step();
        fill_en = 1'b0;
    endtask

    // Waits until every lookup in flight has been answered
    task automatic drain();
        while (pending_q.size() != 0)
            step();
    endtask

    // Random fills and lookups each cycle that mostly use pages of the pool
    task automatic mixed_traffic(int cycles, int fill_pct, int lookup_pct);
        for (int i = 0; i < cycles; i++)
        begin
            fill_en   = fill_rdy && (($urandom % 100) < fill_pct);
            fill.va   = pool[$urandom % POOL_SIZE];
            fill.pa   = vtp_tlb_pkg::tlb_pa_page_t'($urandom);
            lookup_en = lookup_rdy && (($urandom % 100) < lookup_pct);
            if (($urandom % 4) == 0)
                lookup_va = vtp_tlb_pkg::tlb_va_page_t'($urandom);
            else
                lookup_va = pool[$urandom % POOL_SIZE];
            step();
        end
        fill_en   = 1'b0;
        lookup_en = 1'b0;
    endtask

    task automatic finish_test(string name, int errs_before);
        int errs;
        errs = total_errors() - errs_before;
        if (errs == 0)
            tests_pass++;
        else
            tests_fail++;
        $display("test %s done with %0d errors", name, errs);
    endtask

    // ====================
    // Tests
    // ====================

    task automatic test_after_reset();
        int errs;
        int n;
        errs = total_errors();
        n    = 0;
        while (!(lookup_rdy && fill_rdy) && (n < 2 * `TLB_SETS))
        begin
            step();
            n++;
        end
        if (n != `TLB_SETS)
            report_mismatch("lookup_rdy rise cycle", `TLB_SETS, n);
        // Nothing is filled yet, so every lookup must miss
        for (int k = 0; k < 4; k++)
            lookup(vtp_tlb_pkg::tlb_va_page_t'($urandom));
        drain();
        finish_test("after_reset", errs);
    endtask

    task automatic test_fill_lookup();
        int                        errs;
        vtp_tlb_pkg::tlb_va_page_t va;
        errs = total_errors();
        va   = vtp_tlb_pkg::tlb_va_page_t'($urandom);
        fill_entry(va, vtp_tlb_pkg::tlb_pa_page_t'($urandom));
        lookup(va);
        // Same set with a tag that differs in its lowest bit
        lookup(va ^ vtp_tlb_pkg::tlb_va_page_t'(1 << TAG_LSB));
        drain();
        finish_test("fill_lookup", errs);
    endtask

    task automatic test_fill_timing();
        int errs;
        errs = total_errors();
        mixed_traffic(16, 100, 100);
        drain();
        finish_test("fill_timing", errs);
    endtask

    // Five fills into one set where the fifth overwrites the way of the first
    task automatic test_replacement();
        int                        errs;
        vtp_tlb_pkg::tlb_idx_t     set_idx;
        vtp_tlb_pkg::tlb_tag_t     tag;
        vtp_tlb_pkg::tlb_va_page_t vas [5];
        errs    = total_errors();
        set_idx = vtp_tlb_pkg::tlb_idx_t'($urandom);
        tag     = vtp_tlb_pkg::tlb_tag_t'($urandom);
        for (int k = 0; k < 5; k++)
        begin
            vas[k] = {tag + vtp_tlb_pkg::tlb_tag_t'(k), set_idx};
            fill_entry(vas[k], vtp_tlb_pkg::tlb_pa_page_t'($urandom));
        end
        for (int k = 0; k < 5; k++)
            lookup(vas[k]);
        drain();
        finish_test("replacement", errs);
    endtask

    task automatic test_random_mix();
        int errs;
        errs = total_errors();
        mixed_traffic(300, 20, 70);
        drain();
        finish_test("random_mix", errs);
    endtask

    // ====================
    // Main sequence
    // ====================

    initial
    begin
        void'($urandom(32'h34a9));
        reset        = 1'b1;
        lookup_en    = 1'b0;
        lookup_va    = '0;
        fill_en      = 1'b0;
        fill         = '0;
        model_victim = 0;
        cycle        = 0;
        err_cnt      = 0;
        tests_pass   = 0;
        tests_fail   = 0;
        for (int s = 0; s < `TLB_SETS; s++)
            for (int w = 0; w < `TLB_WAYS; w++)
                model[s][w] = '0;
        // Pool pages share four sets, so fills keep evicting each other
        for (int i = 0; i < POOL_SIZE; i++)
            pool[i] = vtp_tlb_pkg::tlb_va_page_t'($urandom);
        for (int i = 4; i < POOL_SIZE; i++)
            pool[i][TAG_LSB-1:0] = pool[i % 4][TAG_LSB-1:0];

        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        test_after_reset();
        test_fill_lookup();
        test_fill_timing();
        test_replacement();
        test_random_mix();

        $display("Summary: %0d tests passing, %0d tests failing, %0d errors",
                 tests_pass, tests_fail, total_errors());
        if ((tests_fail == 0) && (total_errors() == 0))
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

//--- vtp_tlb.f
+incdir+hdl
hdl/vtp_tlb_pkg.sv
hdl/tlb_way_ram.sv
hdl/tlb_init_sweep.sv
hdl/tlb_fill_ctrl.sv
hdl/tlb_lookup_pipe.sv
hdl/vtp_tlb.sv
verif/tb_clock_gen.sv
verif/vtp_tlb_checker.sv
verif/vtp_tlb_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := vtp_tlb_tb
FILELIST   := vtp_tlb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Test completed successfully
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps -Wall
RUN_ARGS   := +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
